//--- Bender.yml
package:
  name: cache

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/cache_lanes.sv
      - design/cache_store.sv
      - design/cache_ctrl.sv
      - design/cache_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/cache_sva.sv
      - bench/cache_tb.sv

//--- bench/cache_sva.sv
`timescale 1ns/1ps

module cache_sva (
    input logic                clk,
    input logic                rstn,
    input logic                req,
    input cache_pkg::cpu_req_t cpu,
    input logic                ready,
    input logic                rvalid,
    input logic                mem_valid,
    input cache_pkg::mem_req_t mem,
    input logic                gnt,
    input logic                mem_rvalid
);
    int   fail_count = 0;
    logic last_load;  // Last accepted access was a load

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_load <= 1'b0;
        end else if (req && ready) begin
            last_load <= !cpu.wr;
        end
    end

    // Request held until granted
    mem_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_valid && !gnt |=> mem_valid && $stable(mem))
        else begin
            $error("memory request changed before its grant");
            fail_count++;
        end

    busy_not_ready: assert property (@(posedge clk) disable iff (!rstn)
        mem_valid |-> !ready)
        else begin
            $error("ready high during a memory request");
            fail_count++;
        end

    // Load hit now or the edge after the line of a load miss
    no_store_rvalid: assert property (@(posedge clk) disable iff (!rstn)
        rvalid |-> (req && ready && !cpu.wr) || ($past(mem_rvalid) && last_load))
        else begin
            $error("rvalid without a load to answer");
            fail_count++;
        end

    reset_state: assert property (@(posedge clk) $rose(rstn) |-> ready && !mem_valid)
        else begin
            $error("wrong port state after reset");
            fail_count++;
        end

endmodule

bind cache_top cache_sva u_sva (.*);

//--- bench/cache_tb.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;
    import cache_pkg::*;

    localparam addr_t BASE       = 32'h0000_4000;
    localparam int    WIN_LINES  = 16;  // Four lines alias onto each index
    localparam int    LB         = `CACHE_LINE_BYTES;
    localparam int    WAIT_LIMIT = 200;
    localparam int    N_RANDOM   = 400;

    logic     clk;
    logic     rstn;
    logic     req;
    cpu_req_t cpu;
    logic     ready;
    logic     rvalid;
    word_t    rdata;
    logic     mem_valid;
    mem_req_t mem;
    logic     gnt;
    logic     mem_rvalid;
    line_t    mem_rdata;

    logic [15:0] lfsr = 16'd65223;
    logic [7:0]  shadow [WIN_LINES*LB];  // Bytes as the CPU sees them
    line_t       backing [WIN_LINES];
    logic        res_valid [`CACHE_N_LINES];
    logic        res_dirty [`CACHE_N_LINES];
    addr_t       res_line [`CACHE_N_LINES];
    word_t       exp_load [$];
    mem_req_t    exp_mem [$];

    cache_top DUT (.*);

    always #4 clk = ~clk;

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_step();
        end
        return v;
    endfunction

    function automatic logic [7:0] fill_byte(addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ {a[2:0], a[7:3]} ^ 8'h96;
    endfunction

    function automatic int size_bytes(size_e s);
        return (s == SIZE_BYTE) ? 1 : (s == SIZE_HALF) ? 2 : 4;
    endfunction

    function automatic line_t shadow_line(addr_t la);
        line_t l;
        for (int b = 0; b < LB; b++) begin
            l[8*b +: 8] = shadow[int'(la - BASE) + b];
        end
        return l;
    endfunction

    // Expected load word with the upper bytes zero
    function automatic word_t expected_load(addr_t addr, size_e size);
        word_t w;
        int    n;
        int    o;
        n = size_bytes(size);
        o = int'(addr - BASE) & ~(n - 1);
        w = '0;
        for (int k = 0; k < n; k++) begin
            w[8*k +: 8] = shadow[o + k];
        end
        return w;
    endfunction

    function automatic void apply_store(cpu_req_t a);
        int n;
        int o;
        n = size_bytes(a.size);
        o = int'(a.addr - BASE) & ~(n - 1);
        for (int k = 0; k < n; k++) begin
            shadow[o + k] = a.wdata[8*((o + k) % 4) +: 8];  // Lane aligned data
        end
    endfunction

    function automatic cpu_req_t random_req();
        cpu_req_t a;
        a.wr    = lfsr_step();
        a.size  = size_e'(rand_bits(2) % 3);
        a.addr  = BASE + rand_bits(4) * LB + rand_bits(4);
        a.addr  = a.addr & ~addr_t'(size_bytes(a.size) - 1);
        a.wdata = word_t'(rand_bits(32));
        return a;
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    // Write data only matters for a writeback
    task automatic check_mem_req(string name, mem_req_t got, mem_req_t exp);
        if (got.we !== exp.we || got.addr !== exp.addr ||
                (exp.we && got.wdata !== exp.wdata)) begin
            stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    // Model of a direct mapped write-back cache with write allocate
    task automatic predict(cpu_req_t a, output logic hit);
        index_t idx;
        addr_t  la;
        idx = a.addr[OFFSET_BITS +: INDEX_BITS];
        la  = a.addr & ~addr_t'(LB - 1);
        hit = res_valid[idx] && (res_line[idx] == la);
        if (!hit) begin
            if (res_valid[idx] && res_dirty[idx]) begin
                exp_mem.push_back(mem_req_t'{1'b1, res_line[idx], shadow_line(res_line[idx])});
            end
            exp_mem.push_back(mem_req_t'{1'b0, la, '0});
            res_valid[idx] = 1'b1;
            res_line[idx]  = la;
            res_dirty[idx] = 1'b0;
        end
        if (a.wr) begin
            res_dirty[idx] = 1'b1;
            apply_store(a);
        end else begin
            exp_load.push_back(expected_load(a.addr, a.size));
        end
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic do_access(cpu_req_t a);
        logic hit;
        int   waits;
        predict(a, hit);
        req = 1'b1;
        cpu = a;
        @(negedge clk);
        check_bit("ready", ready, 1'b1);  // Only one access outstanding
        check_bit("rvalid", rvalid, hit && !a.wr);
        @(posedge clk);
        #1;
        req = 1'b0;
        if (!hit) begin
            @(negedge clk);
            check_bit("ready", ready, 1'b0);
            waits = 0;
            while (!ready) begin
                waits++;
                if (waits > WAIT_LIMIT) begin
                    stop_run("Timeout: a cache miss never completed");
                end
                @(negedge clk);
            end
            check_bit("rvalid", rvalid, !a.wr);
            @(posedge clk);
            #1;
        end
    endtask

    // Called 1 ns after a rising edge with a request pending
    task automatic serve_mem();
        mem_req_t r;
        int       line_no;
        r = mem;
        if (exp_mem.size() == 0) begin
            stop_run("Memory request issued with no miss outstanding");
        end
        check_mem_req("mem", r, exp_mem.pop_front());
        line_no = int'(r.addr - BASE) / LB;
        repeat (rand_bits(2)) begin  // Grant after 0 to 3 cycles
            @(posedge clk);
            #1;
        end
        gnt = 1'b1;
        @(posedge clk);
        #1;
        gnt = 1'b0;
        if (r.we) begin
            backing[line_no] = r.wdata;
        end else begin
            repeat (rand_bits(2)) begin  // Line 1 to 4 cycles after the grant
                @(posedge clk);
                #1;
            end
            mem_rvalid = 1'b1;
            mem_rdata  = backing[line_no];
            @(posedge clk);
            #1;
            mem_rvalid = 1'b0;
        end
    endtask

    initial begin : memory_model
        forever begin
            @(posedge clk);
            #1;
            while (rstn && mem_valid) begin
                serve_mem();
            end
        end
    end

    initial begin : compare_loads
        forever begin
            @(negedge clk);
            if (rstn && rvalid) begin
                if (exp_load.size() == 0) begin
                    stop_run("rvalid seen with no load outstanding");
                end
                check_word("rdata", rdata, exp_load.pop_front());
            end
            if (DUT.u_sva.fail_count != 0) begin
                stop_run("A protocol assertion failed");
            end
        end
    end

    initial begin : main
        int waits;
        clk        = 1'b0;
        rstn       = 1'b0;
        req        = 1'b0;
        cpu        = '0;
        gnt        = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        for (int i = 0; i < WIN_LINES*LB; i++) begin
            shadow[i] = fill_byte(BASE + i);
        end
        for (int l = 0; l < WIN_LINES; l++) begin
            backing[l] = shadow_line(BASE + l*LB);
        end
        for (int i = 0; i < `CACHE_N_LINES; i++) begin
            res_valid[i] = 1'b0;
            res_dirty[i] = 1'b0;
            res_line[i]  = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;
        do_access(cpu_req_t'{1'b0, BASE + 32'h04, 32'h0, SIZE_WORD});  // Miss then hit
        do_access(cpu_req_t'{1'b0, BASE + 32'h04, 32'h0, SIZE_WORD});
        do_access(cpu_req_t'{1'b0, BASE + 32'h05, 32'h0, SIZE_BYTE});
        do_access(cpu_req_t'{1'b0, BASE + 32'h06, 32'h0, SIZE_HALF});
        do_access(cpu_req_t'{1'b1, BASE + 32'h09, 32'h1122_3344, SIZE_BYTE});
        do_access(cpu_req_t'{1'b1, BASE + 32'h0a, 32'haabb_ccdd, SIZE_HALF});
        do_access(cpu_req_t'{1'b0, BASE + 32'h08, 32'h0, SIZE_WORD});
        // Dirty victim at the same index goes back first
        do_access(cpu_req_t'{1'b0, BASE + 32'h40, 32'h0, SIZE_WORD});
        do_access(cpu_req_t'{1'b0, BASE + 32'h08, 32'h0, SIZE_WORD});
        do_access(cpu_req_t'{1'b1, BASE + 32'h8c, 32'hdead_beef, SIZE_WORD});
        do_access(cpu_req_t'{1'b0, BASE + 32'h8c, 32'h0, SIZE_WORD});
        for (int n = 0; n < N_RANDOM; n++) begin
            do_access(random_req());
        end
        waits = 0;
        while (exp_load.size() != 0 || exp_mem.size() != 0) begin
            waits++;
            if (waits > WAIT_LIMIT) begin
                stop_run("Timeout: expected responses never arrived");
            end
            @(negedge clk);
        end
        if (DUT.u_sva.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            stop_run("A protocol assertion failed");
        end
    end

endmodule

//--- design/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Cache geometry

// Byte address width
`define CACHE_ADDR_W 32

// Bytes per line, a power of two of at least 4
`define CACHE_LINE_BYTES 16

`define CACHE_N_LINES 4  // Direct mapped, one line per index

`endif

//--- design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                clk,
    input  logic                rstn,

    // CPU port
    input  logic                req,
    input  cache_pkg::cpu_req_t cpu,
    output logic                ready,
    output logic                rvalid,
    output cache_pkg::word_t    rdata,

    // Memory port
    output logic                mem_valid,
    output cache_pkg::mem_req_t mem,
    input  logic                gnt,
    input  logic                mem_rvalid,
    input  cache_pkg::line_t    mem_rdata,

    // Tag and data store
    output cache_pkg::index_t   rd_index,
    input  cache_pkg::tag_t     rd_tag,
    input  logic                rd_valid,
    input  logic                rd_dirty,
    input  cache_pkg::line_t    rd_line,
    output logic                wr_en,
    output cache_pkg::tag_t     wr_tag,
    output cache_pkg::line_t    wr_line,
    output logic                wr_dirty
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITEBACK,
        S_REFILL
    } state_e;

    state_e   state;
    cpu_req_t pend;       // Missed access waiting for its line
    logic     rvalid_q;
    word_t    rdata_q;

    logic     idle;
    cpu_req_t acc;        // Access on the lanes this cycle
    woff_t    acc_woff;
    boff_t    acc_boff;
    logic     hit;
    logic     accept;
    logic     load_hit;
    logic     store_hit;
    logic     miss;
    logic     victim_dirty;
    logic     granted;
    logic     refill_done;
    line_t    lane_line;
    word_t    load_word;
    line_t    merged_line;

    assign idle = (state == S_IDLE);

    // New access in idle, the pending one while a miss is served
    assign acc      = idle ? cpu : pend;
    assign acc_woff = addr_woff(acc.addr);
    assign acc_boff = addr_boff(acc.addr);
    assign rd_index = addr_index(acc.addr);

    assign hit = rd_valid && (rd_tag == addr_tag(cpu.addr));

    // The registered load response owns its cycle, a new access waits one more
    assign ready  = idle && !(rvalid_q && req);
    assign accept = req && ready;

    assign load_hit     = accept && !cpu.wr && hit;
    assign store_hit    = accept && cpu.wr && hit;
    assign miss         = accept && !hit;
    assign victim_dirty = rd_valid && rd_dirty;

    assign granted = mem_valid && gnt;
    // Line arrives after the read grant
    assign refill_done = (state == S_REFILL) && !mem_valid && mem_rvalid;

    assign lane_line = (state == S_REFILL) ? mem_rdata : rd_line;

    cache_lanes u_lanes (
        .line        (lane_line),
        .woff        (acc_woff),
        .boff        (acc_boff),
        .size        (acc.size),
        .wdata       (acc.wdata),
        .load_word   (load_word),
        .merged_line (merged_line)
    );

    // Store hit or refill, both at the read index
    assign wr_en    = store_hit || refill_done;
    assign wr_tag   = addr_tag(acc.addr);
    assign wr_line  = acc.wr ? merged_line : mem_rdata;  // Store miss merges into refill
    assign wr_dirty = acc.wr;

    assign rvalid = load_hit || rvalid_q;
    assign rdata  = rvalid_q ? rdata_q : load_word;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= S_IDLE;
            mem_valid <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            rvalid_q <= refill_done && !pend.wr;
            case (state)
                S_IDLE: begin
                    if (miss) begin
                        mem_valid <= 1'b1;
                        state     <= victim_dirty ? S_WRITEBACK : S_REFILL;
                    end
                end
                S_WRITEBACK: begin
                    if (granted) begin
                        state <= S_REFILL;  // Read request follows directly
                    end
                end
                S_REFILL: begin
                    if (granted) begin
                        mem_valid <= 1'b0;
                    end
                    if (refill_done) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Pending access, memory request and load response
    always_ff @(posedge clk) begin
        if (miss) begin
            pend      <= cpu;
            mem.we    <= victim_dirty;
            mem.wdata <= rd_line;
            if (victim_dirty) begin
                mem.addr <= victim_addr(rd_tag, rd_index);
            end else begin
                mem.addr <= line_addr(cpu.addr);
            end
        end
        if ((state == S_WRITEBACK) && granted) begin
            mem.we   <= 1'b0;
            mem.addr <= line_addr(pend.addr);
        end
        if (refill_done) begin
            rdata_q <= load_word;
        end
    end

endmodule

//--- design/cache_lanes.sv
`timescale 1ns/1ps

module cache_lanes (
    input  cache_pkg::line_t line,
    input  cache_pkg::woff_t woff,
    input  cache_pkg::boff_t boff,
    input  cache_pkg::size_e size,
    input  cache_pkg::word_t wdata,
    output cache_pkg::word_t load_word,
    output cache_pkg::line_t merged_line
);
    import cache_pkg::*;

    word_t sel_word;
    word_t merged_word;
    strb_t strb;

    // Addressed word of the line
    assign sel_word = line[32*woff +: 32];

    // Load data, zero extended
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                load_word = {24'h0, sel_word[8*boff +: 8]};
            end
            SIZE_HALF: begin
                load_word = {16'h0, sel_word[16*boff[1] +: 16]};
            end
            default: begin
                load_word = sel_word;
            end
        endcase
    end

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                strb = strb_t'(1) << boff;
            end
            SIZE_HALF: begin
                strb = boff[1] ? 4'b1100 : 4'b0011;  // Halves are aligned
            end
            default: begin
                strb = 4'b1111;
            end
        endcase
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged_word[8*b +: 8] = wdata[8*b +: 8];
            end else begin
                merged_word[8*b +: 8] = sel_word[8*b +: 8];
            end
        end
    end

    // Other words of the line pass unchanged
    always_comb begin
        merged_line = line;
        merged_line[32*woff +: 32] = merged_word;
    end

endmodule

//--- design/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    localparam int OFFSET_BITS    = $clog2(`CACHE_LINE_BYTES);
    localparam int INDEX_BITS     = $clog2(`CACHE_N_LINES);
    localparam int TAG_BITS       = `CACHE_ADDR_W - OFFSET_BITS - INDEX_BITS;
    localparam int WORDS_PER_LINE = `CACHE_LINE_BYTES / 4;
    localparam int WOFF_BITS      = $clog2(WORDS_PER_LINE);

    typedef logic [`CACHE_ADDR_W-1:0]       addr_t;
    typedef logic [31:0]                    word_t;
    typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;
    typedef logic [INDEX_BITS-1:0]          index_t;
    typedef logic [TAG_BITS-1:0]            tag_t;
    typedef logic [WOFF_BITS-1:0]           woff_t;
    typedef logic [1:0]                     boff_t;
    typedef logic [3:0]                     strb_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    // Store data is lane aligned, byte n of the word sits in wdata[8n+7:8n]
    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t wdata;
        size_e size;
    } cpu_req_t;

    typedef struct packed {
        logic  we;
        addr_t addr;   // Line aligned
        line_t wdata;
    } mem_req_t;

    function automatic index_t addr_index(addr_t a);
        return a[OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic tag_t addr_tag(addr_t a);
        return a[`CACHE_ADDR_W-1 -: TAG_BITS];
    endfunction

    function automatic woff_t addr_woff(addr_t a);
        return a[2 +: WOFF_BITS];
    endfunction

    function automatic boff_t addr_boff(addr_t a);
        return a[1:0];
    endfunction

    function automatic addr_t line_addr(addr_t a);
        return {a[`CACHE_ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    // Rebuilds the address of the line held at an index
    function automatic addr_t victim_addr(tag_t tag, index_t index);
        return {tag, index, {OFFSET_BITS{1'b0}}};
    endfunction

endpackage

//--- design/cache_store.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_store (
    input  logic              clk,
    input  logic              rstn,
    input  cache_pkg::index_t rd_index,
    output cache_pkg::tag_t   rd_tag,
    output logic              rd_valid,
    output logic              rd_dirty,
    output cache_pkg::line_t  rd_line,
    input  logic              wr_en,
    input  cache_pkg::tag_t   wr_tag,
    input  cache_pkg::line_t  wr_line,
    input  logic              wr_dirty
);
    import cache_pkg::*;

    tag_t  tag_mem  [`CACHE_N_LINES];
    line_t data_mem [`CACHE_N_LINES];

    logic [`CACHE_N_LINES-1:0] valid_q;
    logic [`CACHE_N_LINES-1:0] dirty_q;

    // Asynchronous read
    assign rd_tag   = tag_mem[rd_index];
    assign rd_line  = data_mem[rd_index];
    assign rd_valid = valid_q[rd_index];
    assign rd_dirty = dirty_q[rd_index];

    // Status bits, all lines invalid and clean out of reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[rd_index] <= 1'b1;
            dirty_q[rd_index] <= wr_dirty;
        end
    end

    // Every write fills a whole line at the read index
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[rd_index]  <= wr_tag;
            data_mem[rd_index] <= wr_line;
        end
    end

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                clk,
    input  logic                rstn,

    input  logic                req,
    input  cache_pkg::cpu_req_t cpu,
    output logic                ready,
    output logic                rvalid,
    output cache_pkg::word_t    rdata,

    output logic                mem_valid,
    output cache_pkg::mem_req_t mem,
    input  logic                gnt,
    input  logic                mem_rvalid,
    input  cache_pkg::line_t    mem_rdata
);
    import cache_pkg::*;

    index_t rd_index;
    tag_t   rd_tag;
    logic   rd_valid;
    logic   rd_dirty;
    line_t  rd_line;
    logic   wr_en;
    tag_t   wr_tag;
    line_t  wr_line;
    logic   wr_dirty;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .cpu        (cpu),
        .ready      (ready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .mem_valid  (mem_valid),
        .mem        (mem),
        .gnt        (gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rd_index   (rd_index),
        .rd_tag     (rd_tag),
        .rd_valid   (rd_valid),
        .rd_dirty   (rd_dirty),
        .rd_line    (rd_line),
        .wr_en      (wr_en),
        .wr_tag     (wr_tag),
        .wr_line    (wr_line),
        .wr_dirty   (wr_dirty)
    );

    // One read port, one write port sharing its index
    cache_store u_store (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .rd_tag   (rd_tag),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty),
        .rd_line  (rd_line),
        .wr_en    (wr_en),
        .wr_tag   (wr_tag),
        .wr_line  (wr_line),
        .wr_dirty (wr_dirty)
    );

endmodule

//--- src.f
+incdir+design
design/cache_pkg.sv
design/cache_lanes.sv
design/cache_store.sv
design/cache_ctrl.sv
design/cache_top.sv
bench/cache_sva.sv
bench/cache_tb.sv
